/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ex
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ex_alu_m.sv */
`timescale 1ns/1ps

// Slice ALU. The result is combinational while carry and the zero flag are
// carried from one slice into the next.
module ex_alu_m import ex_pkg::*; (
  input  var logic     i_ex_gck,
  input  var logic     i_ex_rst_n,

  input  var ctr_t     i_ctr,
  input  var logic     i_run,
  input  var alu_op_t  i_op,
  input  var logic     i_inv,
  input  var logic     i_cin,
  input  var slice_t   i_lhs,
  input  var slice_t   i_rhs,

  output var slice_t   o_out,
  output var logic     o_flag_z,
  output var logic     o_flag_n,
  output var logic     o_flag_c,
  output var logic     o_flag_v
);

  slice_t     rhs;
  logic       cin;
  logic [4:0] sum;
  logic       carry_q;
  logic       zero_q;

  // Right operand is inverted for subtracts and compares.
  always_comb rhs = i_inv ? ~i_rhs : i_rhs;

  // Carry in comes from the encoding on the first slice and from the
  // previous slice after that.
  always_comb cin = i_ctr == ctr_t'(0) ? i_cin : carry_q;

  always_comb sum = {1'b0, i_lhs} + {1'b0, rhs} + 5'(cin);

  always_comb begin
    unique case (i_op)
      ALU_AND: o_out = i_lhs & rhs;
      ALU_OR:  o_out = i_lhs | rhs;
      ALU_XOR: o_out = i_lhs ^ rhs;
      default: o_out = sum[3:0];
    endcase
  end

  // Zero covers every slice seen so far, so it is only a full-word zero
  // during slice 3. Negative and overflow are only meaningful there too.
  always_comb o_flag_z = (i_ctr == ctr_t'(0) || zero_q) && o_out == '0;
  always_comb o_flag_n = o_out[3];
  always_comb o_flag_c = sum[4];
  always_comb o_flag_v = (i_lhs[3] == rhs[3]) && (sum[3] != i_lhs[3]);

  // Save the running carry and zero state for the next slice.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      carry_q <= 1'b0;
      zero_q  <= 1'b0;
    end
    else if (i_run) begin
      carry_q <= o_flag_c;
      zero_q  <= o_flag_z;
    end
  end

endmodule

/* ex_cond_m.sv */
`timescale 1ns/1ps

// Predicate register and conditional execution state.
module ex_cond_m import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  input  var ctr_t   i_ctr,
  input  var logic   i_run,
  input  var op_t    i_cmp_op,
  input  var logic   i_cond_wr,
  input  var cond_t  i_cond_data,
  input  var logic   i_pin_pred,
  input  var logic   i_flag_z,
  input  var logic   i_flag_n,
  input  var logic   i_flag_c,
  input  var logic   i_flag_v,

  output var logic   o_skip
);

  logic  pred_q;
  logic  pred_d;
  logic  pin_q;
  cond_t cond_q;
  logic  last;

  // The state only applies while a bit above bit 0 is set. Bit 0 then
  // holds the value P must have for the instruction to run.
  always_comb o_skip = |cond_q[7:1] && (pred_q != cond_q[0]);

  // Effects land at the end of the last slice of a running instruction.
  always_comb last = i_run && i_ctr == ctr_t'(3);

  // The pin bit is only offered on slice 0, so keep it for slice 3.
  always_ff @(posedge i_ex_gck) begin
    if (i_run && i_ctr == ctr_t'(0)) begin
      pin_q <= i_pin_pred;
    end
  end

  // New predicate value from the full-word flags. PIN_IN also copies the
  // sampled pin into P.
  always_comb begin
    pred_d = pred_q;
    if (!o_skip) begin
      unique case (i_cmp_op)
        OP_CMP_EQ:  pred_d = i_flag_z;
        OP_CMP_LT:  pred_d = i_flag_n != i_flag_v;
        OP_CMP_LTU: pred_d = !i_flag_c;
        OP_PIN_IN:  pred_d = pin_q;
        default:    pred_d = pred_q;
      endcase
    end
  end

  // A COND that runs loads new state, otherwise every instruction shifts
  // the state right by one, skipped or not.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
      cond_q <= '0;
    end
    else if (last) begin
      pred_q <= pred_d;
      cond_q <= i_cond_wr && !o_skip ? i_cond_data : cond_t'({1'b0, cond_q[7:1]});
    end
  end

endmodule

/* ex_decode_m.sv */
`timescale 1ns/1ps

// Decoder for the held encoding. Purely combinational.
module ex_decode_m import ex_pkg::*; #(
  parameter int NUM_REGS = 16
) (
  input  var word_t                i_enc,
  input  var logic                 i_run,
  input  var logic                 i_skip,

  output var alu_op_t              o_alu_op,
  output var logic                 o_alu_inv,
  output var logic                 o_alu_cin,
  output var reg_t                 o_lhs_reg,
  output var reg_t                 o_rhs_reg,
  output var logic [NUM_REGS-1:0]  o_reg_wr,
  output var op_t                  o_cmp_op,
  output var logic                 o_cond_wr,
  output var op_t                  o_pin_op,
  output var logic [1:0]           o_pin_idx,
  output var logic                 o_utx
);

  op_t  op;
  reg_t dst;
  logic dst_wr;

  always_comb op  = op_t'(i_enc[OPC_MSB:OPC_LSB]);
  always_comb dst = i_enc[DST_MSB:DST_LSB];

  // ALU controls. Compares are subtracts whose result is only used for the
  // flags. Non-ALU ops read the right operand as register 0 so that the ALU
  // passes the left operand through, which is what UTX sends.
  always_comb begin
    o_alu_op  = ALU_ADD;
    o_alu_inv = 1'b0;
    o_alu_cin = 1'b0;
    o_rhs_reg = i_enc[RHS_MSB:RHS_LSB];

    unique case (op)
      OP_ADD:     ;
      OP_AND:     o_alu_op = ALU_AND;
      OP_OR:      o_alu_op = ALU_OR;
      OP_XOR:     o_alu_op = ALU_XOR;
      OP_SUB, OP_CMP_EQ, OP_CMP_LT, OP_CMP_LTU: begin
        o_alu_inv = 1'b1;
        o_alu_cin = 1'b1;
      end
      default:    o_rhs_reg = '0;
    endcase
  end

  always_comb o_lhs_reg = i_enc[LHS_MSB:LHS_LSB];

  // Only the ALU ops and PIN_IN write a destination register, and only
  // when a slice actually runs and is not skipped.
  always_comb dst_wr = i_run && !i_skip
                    && (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PIN_IN});

  // One-hot destination enables. Bit 0 stays low as register 0 is zero.
  always_comb begin
    o_reg_wr = '0;
    for (int i = 1; i < NUM_REGS; i++) begin
      o_reg_wr[i] = dst_wr && dst == reg_t'(i);
    end
  end

  // Remaining controls go out raw; the units qualify them with run and skip.
  always_comb o_cmp_op  = op;
  always_comb o_cond_wr = op == OP_COND;
  always_comb o_pin_op  = op;
  always_comb o_pin_idx = i_enc[RHS_LSB+1:RHS_LSB];
  always_comb o_utx     = op == OP_UTX;

endmodule

/* ex_greg_m.sv */
`timescale 1ns/1ps

// A single 16-bit general register that is read and written one slice at
// a time. The lowest slice is always the one being worked on.
module ex_greg_m import ex_pkg::*; (
  input  var logic    i_ex_gck,
  input  var logic    i_ex_rst_n,

  input  var logic    i_run,
  input  var logic    i_wr,
  input  var slice_t  i_data,

  output var slice_t  o_data
);

  word_t data_q;
  slice_t in_slice;

  // On a write the new slice takes the place of the one leaving the bottom.
  always_comb in_slice = i_wr ? i_data : data_q[3:0];

  // Rotate right by a slice on every running cycle so that after four
  // cycles the register is back in its original alignment.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      data_q <= '0;
    end
    else if (i_run) begin
      data_q <= {in_slice, data_q[15:4]};
    end
  end

  always_comb o_data = data_q[3:0];

endmodule

/* ex_io_m.sv */
`timescale 1ns/1ps

// Input and output pins plus the UART transmit valid.
module ex_io_m import ex_pkg::*; #(
  parameter int NUM_PINS = 4
) (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,

  input  var ctr_t                 i_ctr,
  input  var logic                 i_run,
  input  var logic                 i_skip,
  input  var op_t                  i_pin_op,
  input  var logic [1:0]           i_pin_idx,
  input  var slice_t               i_lhs,
  input  var logic [NUM_PINS-1:0]  i_io_pins,
  input  var logic                 i_utx,

  output var slice_t               o_pin_data,
  output var logic [NUM_PINS-1:0]  o_io_pins,
  output var logic                 o_utx_vld
);

  logic [NUM_PINS-1:0] in_pins_q;
  logic [NUM_PINS-1:0] out_pins_q;
  logic                idx_ok;

  // Pins past the implemented count are ignored on output and read as 0.
  always_comb idx_ok = int'(i_pin_idx) < NUM_PINS;

  // Input pins are registered every cycle.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      in_pins_q <= '0;
    end
    else begin
      in_pins_q <= i_io_pins;
    end
  end

  // PIN_IN writes the pin into bit 0 and zeros elsewhere, so the data is
  // the pin on slice 0 and zero on the other slices.
  always_comb begin
    o_pin_data = '0;
    if (i_pin_op == OP_PIN_IN && i_ctr == ctr_t'(0) && idx_ok) begin
      o_pin_data = slice_t'(in_pins_q[i_pin_idx]);
    end
  end

  // Bit 0 of the left register is only present on slice 0.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      out_pins_q <= '0;
    end
    else if (i_run && !i_skip && i_ctr == ctr_t'(0)
             && i_pin_op == OP_PIN_OUT && idx_ok) begin
      out_pins_q[i_pin_idx] <= i_lhs[0];
    end
  end

  always_comb o_io_pins = out_pins_q;

  // Valid on every running slice of a UTX. Run stays low during the accept
  // wait, so nothing is offered until the receiver is ready.
  always_comb o_utx_vld = i_run && !i_skip && i_utx;

endmodule

/* ex_operand_m.sv */
`timescale 1ns/1ps

// Picks the current slice of the left and right operand registers.
module ex_operand_m import ex_pkg::*; #(
  parameter int NUM_REGS = 16
) (
  input  var slice_t [NUM_REGS-1:0]  i_regs,
  input  var reg_t                   i_lhs_reg,
  input  var reg_t                   i_rhs_reg,

  output var slice_t                 o_lhs,
  output var slice_t                 o_rhs
);

  // Register 0 and any index past the implemented registers read as zero.
  function automatic slice_t read_slice(input reg_t idx, input slice_t [NUM_REGS-1:0] regs);
    slice_t val;
    val = '0;
    if (idx != '0 && int'(idx) < NUM_REGS) begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb o_lhs = read_slice(i_lhs_reg, i_regs);
  always_comb o_rhs = read_slice(i_rhs_reg, i_regs);

endmodule

/* ex_pkg.sv */
// Shared types and encoding layout for the nibble-serial execute engine.
package ex_pkg;

  // One 4-bit slice of data, the unit processed per clock cycle.
  typedef logic [3:0]  slice_t;

  // A full register value or instruction encoding.
  typedef logic [15:0] word_t;

  // Index of a general register.
  typedef logic [3:0]  reg_t;

  // Slice counter, running 0 to 3 over an instruction.
  typedef logic [1:0]  ctr_t;

  // Conditional execution state loaded by COND.
  typedef logic [7:0]  cond_t;

  // Opcodes held in the top four bits of an encoding.
  typedef enum logic [3:0] {
    OP_ADD     = 4'h0,
    OP_SUB     = 4'h1,
    OP_AND     = 4'h2,
    OP_OR      = 4'h3,
    OP_XOR     = 4'h4,
    OP_CMP_EQ  = 4'h5,
    OP_CMP_LT  = 4'h6,
    OP_CMP_LTU = 4'h7,
    OP_COND    = 4'h8,
    OP_PIN_IN  = 4'h9,
    OP_PIN_OUT = 4'ha,
    OP_UTX     = 4'hb
  } op_t;

  // ALU functions. Subtraction is an add with the right operand inverted
  // and a carry in of one.
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  // Sequencer states.
  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

  // Bit positions of the encoding fields.
  localparam int OPC_MSB = 15;
  localparam int OPC_LSB = 12;
  localparam int DST_MSB = 11;
  localparam int DST_LSB = 8;
  localparam int LHS_MSB = 7;
  localparam int LHS_LSB = 4;
  localparam int RHS_MSB = 3;
  localparam int RHS_LSB = 0;

endpackage

/* ex_seq_m.sv */
`timescale 1ns/1ps

// Instruction sequencer. Takes one encoding at a time and walks it through
// the four slice cycles.
module ex_seq_m import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  input  var word_t  i_enc,
  input  var logic   i_enc_vld,
  input  var logic   i_utx_acp,
  input  var logic   i_skip,

  output var word_t  o_enc,
  output var ctr_t   o_ctr,
  output var logic   o_run,
  output var logic   o_stall
);

  seq_state_t state_q;
  ctr_t       ctr_q;
  word_t      enc_q;
  logic       utx_wait;
  logic       take;

  // A UTX that is going to run must see accept on slice 0 before any of its
  // slices are sent, so it holds at slice 0 until then.
  always_comb utx_wait = state_q == SEQ_RUN
                      && ctr_q == ctr_t'(0)
                      && op_t'(enc_q[OPC_MSB:OPC_LSB]) == OP_UTX
                      && !i_skip
                      && !i_utx_acp;

  // A slice executes on every busy cycle except while waiting for accept.
  always_comb o_run = state_q == SEQ_RUN && !utx_wait;

  // The source must hold its encoding until the last slice of the current
  // instruction, or for as long as the UART wait lasts.
  always_comb o_stall = (state_q == SEQ_RUN && ctr_q != ctr_t'(3)) || utx_wait;

  // New encoding is taken when offered and not stalled.
  always_comb take = i_enc_vld && !o_stall;

  // State and slice counter. An encoding taken at the end of slice 3 starts
  // straight away at slice 0 on the next cycle.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      state_q <= SEQ_IDLE;
      ctr_q   <= '0;
    end
    else if (state_q == SEQ_IDLE) begin
      if (take) state_q <= SEQ_RUN;
    end
    else if (o_run) begin
      ctr_q <= ctr_q + ctr_t'(1);
      if (ctr_q == ctr_t'(3) && !take) state_q <= SEQ_IDLE;
    end
  end

  // Held encoding. Cleared at reset so the decoder never sees unknowns.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      enc_q <= '0;
    end
    else if (take) begin
      enc_q <= i_enc;
    end
  end

  always_comb o_enc = enc_q;
  always_comb o_ctr = ctr_q;

endmodule

/* ex_top_m.sv */
`timescale 1ns/1ps

// Top level of the nibble-serial execute engine.
module ex_top_m import ex_pkg::*; #(
  parameter int NUM_REGS = 16,
  parameter int NUM_PINS = 4
) (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,

  input  var word_t                i_ex_enc,
  input  var logic                 i_ex_enc_vld,
  output var logic                 o_ex_stall,

  output var slice_t               o_ex_utx_data,
  output var logic                 o_ex_utx_vld,
  input  var logic                 i_ex_utx_acp,

  input  var logic [NUM_PINS-1:0]  i_ex_io_pins,
  output var logic [NUM_PINS-1:0]  o_ex_io_pins
);

  word_t                 enc;
  ctr_t                  ctr;
  logic                  run;
  logic                  skip;

  alu_op_t               alu_op;
  logic                  alu_inv;
  logic                  alu_cin;
  reg_t                  lhs_reg;
  reg_t                  rhs_reg;
  logic [NUM_REGS-1:0]   reg_wr;
  op_t                   cmp_op;
  logic                  cond_wr;
  op_t                   pin_op;
  logic [1:0]            pin_idx;
  logic                  utx;

  slice_t [NUM_REGS-1:0] regs;
  slice_t                lhs;
  slice_t                rhs;
  slice_t                alu_out;
  slice_t                pin_data;
  slice_t                wr_data;
  logic                  flag_z;
  logic                  flag_n;
  logic                  flag_c;
  logic                  flag_v;

  ex_seq_m seq_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_enc      (i_ex_enc),
    .i_enc_vld  (i_ex_enc_vld),
    .i_utx_acp  (i_ex_utx_acp),
    .i_skip     (skip),
    .o_enc      (enc),
    .o_ctr      (ctr),
    .o_run      (run),
    .o_stall    (o_ex_stall)
  );

  ex_decode_m #(.NUM_REGS(NUM_REGS)) decode_u (
    .i_enc      (enc),
    .i_run      (run),
    .i_skip     (skip),
    .o_alu_op   (alu_op),
    .o_alu_inv  (alu_inv),
    .o_alu_cin  (alu_cin),
    .o_lhs_reg  (lhs_reg),
    .o_rhs_reg  (rhs_reg),
    .o_reg_wr   (reg_wr),
    .o_cmp_op   (cmp_op),
    .o_cond_wr  (cond_wr),
    .o_pin_op   (pin_op),
    .o_pin_idx  (pin_idx),
    .o_utx      (utx)
  );

  // Register 0 has no storage and always supplies zero.
  assign regs[0] = '0;

  for (genvar g = 1; g < NUM_REGS; g++) begin : g_reg
    ex_greg_m greg_u (
      .i_ex_gck   (i_ex_gck),
      .i_ex_rst_n (i_ex_rst_n),
      .i_run      (run),
      .i_wr       (reg_wr[g]),
      .i_data     (wr_data),
      .o_data     (regs[g])
    );
  end

  ex_operand_m #(.NUM_REGS(NUM_REGS)) operand_u (
    .i_regs     (regs),
    .i_lhs_reg  (lhs_reg),
    .i_rhs_reg  (rhs_reg),
    .o_lhs      (lhs),
    .o_rhs      (rhs)
  );

  ex_alu_m alu_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_ctr      (ctr),
    .i_run      (run),
    .i_op       (alu_op),
    .i_inv      (alu_inv),
    .i_cin      (alu_cin),
    .i_lhs      (lhs),
    .i_rhs      (rhs),
    .o_out      (alu_out),
    .o_flag_z   (flag_z),
    .o_flag_n   (flag_n),
    .o_flag_c   (flag_c),
    .o_flag_v   (flag_v)
  );

  ex_cond_m cond_u (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),
    .i_ctr       (ctr),
    .i_run       (run),
    .i_cmp_op    (cmp_op),
    .i_cond_wr   (cond_wr),
    .i_cond_data (enc[7:0]),
    .i_pin_pred  (pin_data[0]),
    .i_flag_z    (flag_z),
    .i_flag_n    (flag_n),
    .i_flag_c    (flag_c),
    .i_flag_v    (flag_v),
    .o_skip      (skip)
  );

  ex_io_m #(.NUM_PINS(NUM_PINS)) io_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_ctr      (ctr),
    .i_run      (run),
    .i_skip     (skip),
    .i_pin_op   (pin_op),
    .i_pin_idx  (pin_idx),
    .i_lhs      (lhs),
    .i_io_pins  (i_ex_io_pins),
    .i_utx      (utx),
    .o_pin_data (pin_data),
    .o_io_pins  (o_ex_io_pins),
    .o_utx_vld  (o_ex_utx_vld)
  );

  // Registers take the pin slice for PIN_IN and the ALU result otherwise.
  always_comb wr_data = pin_op == OP_PIN_IN ? pin_data : alu_out;

  // UTX runs the left register through the ALU unchanged.
  always_comb o_ex_utx_data = alu_out;

endmodule

/* sources.f */
ex_pkg.sv
ex_seq_m.sv
ex_decode_m.sv
ex_greg_m.sv
ex_operand_m.sv
ex_alu_m.sv
ex_cond_m.sv
ex_io_m.sv
ex_top_m.sv
tb_ex_clk.sv
tb_ex_asserts.sv
tb_ex.sv

/* tb_ex.sv */
`timescale 1ns/1ps

// Directed testbench for the nibble-serial execute engine.
module tb_ex import ex_pkg::*;;

  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 6000;
  localparam int INSTR_LIMIT = 100;

  logic       clk;
  logic       rst_n;
  word_t      enc;
  logic       enc_vld;
  logic       stall;
  slice_t     utx_data;
  logic       utx_vld;
  logic       utx_acp;
  logic [3:0] pins_in;
  logic [3:0] pins_out;

  integer     seed = 32'h18e3_a861;
  int         errors = 0;
  string      test_name = "reset";
  logic       acp_hold = 1'b0;
  word_t      rx_word = '0;
  int         rx_cnt = 0;
  word_t      rx_q[$];

  tb_ex_clk clk_u (.o_clk(clk));

  ex_top_m #(.NUM_REGS(16), .NUM_PINS(4)) uut (
    .i_ex_gck      (clk),
    .i_ex_rst_n    (rst_n),
    .i_ex_enc      (enc),
    .i_ex_enc_vld  (enc_vld),
    .o_ex_stall    (stall),
    .o_ex_utx_data (utx_data),
    .o_ex_utx_vld  (utx_vld),
    .i_ex_utx_acp  (utx_acp),
    .i_ex_io_pins  (pins_in),
    .o_ex_io_pins  (pins_out)
  );

  // Every input has a known value from time zero.
  initial begin
    rst_n   = 1'b0;
    enc     = '0;
    enc_vld = 1'b0;
    utx_acp = 1'b0;
    pins_in = '0;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string label, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error: %s %s expected %h actual %h", test_name, label, exp, act);
      stop_run("value mismatch, run stopped");
    end
  endtask

  // The receiver randomly delays accept unless a test holds it low.
  always @(posedge clk) begin
    if (acp_hold) utx_acp <= 1'b0;
    else utx_acp <= ($random(seed) & 3) != 0;
  end

  // UART receiver. Slices come least significant first on back to back cycles.
  always @(negedge clk) begin
    if (rst_n && utx_vld) begin
      rx_word = {utx_data, rx_word[15:4]};
      rx_cnt++;
      if (rx_cnt == 4) begin
        rx_q.push_back(rx_word);
        rx_cnt = 0;
      end
    end
    else if (rx_cnt != 0) begin
      stop_run("UART valid dropped in the middle of a word");
    end
  end

  // Watchdog sized from the number of tests.
  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
    stop_run("watchdog timeout, the tests did not finish in time");
  end

  function automatic word_t enc_of(input op_t op, input reg_t d, input reg_t l,
                                   input reg_t r);
    return {op, d, l, r};
  endfunction

  // Offer an encoding and return right after the edge that takes it.
  task automatic issue_enc(input word_t w);
    int n;
    n = 0;
    @(posedge clk);
    enc     <= w;
    enc_vld <= 1'b1;
    @(negedge clk);
    while (stall) begin
      n++;
      if (n > INSTR_LIMIT) stop_run("encoding was never taken");
      @(negedge clk);
    end
    @(posedge clk);
    enc_vld <= 1'b0;
  endtask

  // Wait for the last slice, then for the edge that completes it.
  task automatic finish_instr();
    int n;
    n = 0;
    @(negedge clk);
    while (stall) begin
      n++;
      if (n > INSTR_LIMIT) stop_run("instruction did not complete");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic exec_instr(input word_t w);
    issue_enc(w);
    finish_instr();
  endtask

  // Build a constant by doubling, adding the one held in register 15.
  task automatic load_const(input reg_t d, input word_t v);
    exec_instr(enc_of(OP_XOR, d, d, d));
    for (int i = 15; i >= 0; i--) begin
      exec_instr(enc_of(OP_ADD, d, d, d));
      if (v[i]) exec_instr(enc_of(OP_ADD, d, d, 4'hf));
    end
  endtask

  task automatic expect_word(input string label, input word_t exp);
    word_t got;
    check_value({label, " word count"}, 1, rx_q.size());
    got = rx_q.pop_front();
    check_value(label, exp, got);
  endtask

  task automatic expect_none(input string label);
    check_value({label, " word count"}, 0, rx_q.size());
  endtask

  task automatic send_reg(input string label, input reg_t r, input word_t exp);
    exec_instr(enc_of(OP_UTX, 4'h0, r, 4'h0));
    expect_word(label, exp);
  endtask

  function automatic word_t alu_model(input op_t op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      default: return a ^ b;
    endcase
  endfunction

  task automatic test_reset_utx();
    test_name = "reset_utx";
    send_reg("r1", 4'h1, 16'h0000);
    send_reg("r5", 4'h5, 16'h0000);
    // Writes aimed at register 0 are dropped.
    exec_instr(enc_of(OP_PIN_IN, 4'h0, 4'h0, 4'h0));
    exec_instr(enc_of(OP_ADD, 4'h0, 4'h0, 4'h0));
    send_reg("r0", 4'h0, 16'h0000);
    // Register 15 keeps a one for the constant builder.
    exec_instr(enc_of(OP_PIN_IN, 4'hf, 4'h0, 4'h0));
    send_reg("r15", 4'hf, 16'h0001);
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    op_t   ops[5];
    test_name = "alu";
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    for (int k = 0; k < 4; k++) begin
      a = k == 0 ? 16'hffff : word_t'($random(seed));
      b = k == 0 ? 16'h0001 : word_t'($random(seed));
      load_const(4'h1, a);
      load_const(4'h2, b);
      send_reg("lhs", 4'h1, a);
      foreach (ops[i]) begin
        exec_instr(enc_of(ops[i], 4'h3, 4'h1, 4'h2));
        send_reg(ops[i].name(), 4'h3, alu_model(ops[i], a, b));
      end
    end
  endtask

  task automatic test_compare();
    word_t a;
    word_t b;
    logic  p;
    op_t   ops[3];
    test_name = "compare";
    ops = '{OP_CMP_EQ, OP_CMP_LT, OP_CMP_LTU};
    for (int k = 0; k < 5; k++) begin
      a = word_t'($random(seed));
      b = k == 1 ? a : word_t'($random(seed));
      load_const(4'h1, a);
      load_const(4'h2, b);
      foreach (ops[i]) begin
        case (ops[i])
          OP_CMP_EQ: p = a == b;
          OP_CMP_LT: p = $signed(a) < $signed(b);
          default:   p = a < b;
        endcase
        exec_instr(enc_of(ops[i], 4'h0, 4'h1, 4'h2));
        exec_instr({OP_COND, 4'h0, 8'b0000_0011});
        exec_instr(enc_of(OP_UTX, 4'h0, 4'h1, 4'h0));
        if (p) expect_word(ops[i].name(), a);
        else expect_none(ops[i].name());
      end
    end
  endtask

  task automatic test_cond_expire();
    test_name = "cond_expire";
    load_const(4'h1, 16'h3c5a);
    // P is clear, and the state asks for P set on the next instruction only.
    // Once it expires, bit 0 still disagrees with P but no longer matters.
    exec_instr(enc_of(OP_CMP_EQ, 4'h0, 4'h1, 4'h0));
    exec_instr({OP_COND, 4'h0, 8'b0000_0011});
    exec_instr(enc_of(OP_UTX, 4'h0, 4'h1, 4'h0));
    expect_none("skipped utx");
    send_reg("expired", 4'h1, 16'h3c5a);
  endtask

  task automatic test_pins();
    logic [3:0] exp_pins;
    test_name = "pins";
    exp_pins = '0;
    for (int i = 0; i < 4; i++) begin
      exec_instr(enc_of(OP_PIN_OUT, 4'h0, 4'hf, reg_t'(i)));
      exp_pins[i] = 1'b1;
      check_value("set pin", exp_pins, pins_out);
    end
    for (int i = 0; i < 4; i++) begin
      exec_instr(enc_of(OP_PIN_OUT, 4'h0, 4'h0, reg_t'(i)));
      exp_pins[i] = 1'b0;
      check_value("clear pin", exp_pins, pins_out);
    end
    @(posedge clk);
    pins_in <= 4'b1010;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      exec_instr(enc_of(OP_PIN_IN, 4'h4, 4'h0, reg_t'(i)));
      send_reg("pin in", 4'h4, word_t'(pins_in[i]));
    end
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    load_const(4'h1, 16'ha5c3);
    acp_hold = 1'b1;
    repeat (2) @(posedge clk);
    issue_enc(enc_of(OP_UTX, 4'h0, 4'h1, 4'h0));
    repeat (20) begin
      @(negedge clk);
      check_value("stall", 1, stall);
      check_value("valid", 0, utx_vld);
    end
    expect_none("held");
    acp_hold = 1'b0;
    finish_instr();
    expect_word("released", 16'ha5c3);
    repeat (8) @(posedge clk);
    expect_none("after release");
  endtask

  initial begin
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    pins_in <= 4'b0001;
    repeat (2) @(posedge clk);
    test_reset_utx();
    test_alu();
    test_compare();
    test_cond_expire();
    test_pins();
    test_backpressure();
    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end
    else begin
      stop_run("errors were recorded during the run");
    end
  end

endmodule

/* tb_ex_asserts.sv */
`timescale 1ns/1ps

// Protocol checks on the top level of the execute engine.
module tb_ex_asserts import ex_pkg::*; #(
  parameter int NUM_PINS = 4
) (
  input var logic                 i_ex_gck,
  input var logic                 i_ex_rst_n,
  input var logic                 i_stall,
  input var logic                 i_utx_vld,
  input var slice_t               i_utx_data,
  input var logic                 i_utx_acp,
  input var logic [NUM_PINS-1:0]  i_io_pins,
  input var logic                 i_run,
  input var ctr_t                 i_ctr,
  input var logic                 i_skip,
  input var op_t                  i_pin_op
);

  // While the sequencer holds slice 0 for a missing accept, no slice may
  // be offered to the receiver.
  a_no_vld_in_wait : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    i_stall && i_ctr == ctr_t'(0) && !i_utx_acp |-> !i_utx_vld)
    else $error("UART valid raised while the stall waits for accept");

  // Output pins move only at the end of slice 0 of a PIN_OUT that runs.
  a_pin_change : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    $changed(i_io_pins) |->
      $past(i_run && !i_skip && i_ctr == ctr_t'(0) && i_pin_op == OP_PIN_OUT))
    else $error("output pins changed without a slice 0 PIN_OUT");

  // Outputs are always known once reset has been released.
  a_no_x : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    !$isunknown({i_stall, i_utx_vld, i_utx_data, i_io_pins}))
    else $error("unknown value on a top level output");

endmodule

bind ex_top_m tb_ex_asserts #(.NUM_PINS(NUM_PINS)) asserts_u (
  .i_ex_gck   (i_ex_gck),
  .i_ex_rst_n (i_ex_rst_n),
  .i_stall    (o_ex_stall),
  .i_utx_vld  (o_ex_utx_vld),
  .i_utx_data (o_ex_utx_data),
  .i_utx_acp  (i_ex_utx_acp),
  .i_io_pins  (o_ex_io_pins),
  .i_run      (run),
  .i_ctr      (ctr),
  .i_skip     (skip),
  .i_pin_op   (pin_op)
);

/* tb_ex_clk.sv */
`timescale 1ns/1ps

// Free running testbench clock with an 8 ns period.
module tb_ex_clk #(
  parameter realtime HALF_PERIOD = 4ns
) (
  output var logic o_clk
);

  initial o_clk = 1'b0;

  // Toggle every half period.
  always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule
